// ==== design/cdec_pkg.sv ====
// cdec shared definitions
// rv32 opcodes, register numbers, quadrant codes and result structs

package cdec_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // field widths
  ////////////////////////////////////////////////////////////////////////////

  // full instruction word
  localparam int unsigned INSTR_W  = 32;
  // compressed parcel
  localparam int unsigned CINSTR_W = 16;

  ////////////////////////////////////////////////////////////////////////////
  // rv32 major opcodes
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_LOAD   = 7'h03;
  localparam logic [6:0] OPCODE_STORE  = 7'h23;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;

  ////////////////////////////////////////////////////////////////////////////
  // registers and fixed encodings
  ////////////////////////////////////////////////////////////////////////////

  // stack pointer, base of the sp-relative forms
  localparam logic [4:0] REG_SP = 5'd2;
  // link register for c.jal and c.jalr
  localparam logic [4:0] REG_RA = 5'd1;

  // 3-bit rvc register field maps onto x8..x15
  localparam logic [1:0] RVC_PRIME_PREFIX = 2'b01;

  // ebreak, no operands
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  // instr[1:0] selects the quadrant, 11 means a full-width word
  localparam logic [1:0] QUAD_C0   = 2'b00;
  localparam logic [1:0] QUAD_C1   = 2'b01;
  localparam logic [1:0] QUAD_C2   = 2'b10;
  localparam logic [1:0] QUAD_FULL = 2'b11;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [INSTR_W-1:0] instr_t;

  // output of one quadrant expander
  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } exp_result_t;

  // registered stage result
  typedef struct packed {
    instr_t instr;
    logic   compressed;
    logic   illegal;
  } dec_result_t;

endpackage

// ==== design/cdec_quad0.sv ====
// quadrant C0 expander
// c.addi4spn, c.lw and c.sw into rv32 words, fp and reserved slots illegal

module cdec_quad0
  import cdec_pkg::*;
(
  input  logic [CINSTR_W-1:0] c_instr_i,
  output exp_result_t         result_o
);

  // x8..x15 register fields
  logic [4:0] rs1_p;
  logic [4:0] rd_rs2_p;

  assign rs1_p    = {RVC_PRIME_PREFIX, c_instr_i[9:7]};
  assign rd_rs2_p = {RVC_PRIME_PREFIX, c_instr_i[4:2]};

  always_comb begin
    result_o = '0;

    case (c_instr_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', x2, nzuimm
        result_o.instr = {2'b00, c_instr_i[10:7], c_instr_i[12:11], c_instr_i[5],
                          c_instr_i[6], 2'b00, REG_SP, 3'b000, rd_rs2_p, OPCODE_OPIMM};
        // all-zero immediate is reserved, covers the all-zero parcel too
        result_o.illegal = (c_instr_i[12:5] == 8'h00);
      end

      3'b010: begin
        // c.lw -> lw rd', uimm(rs1')
        result_o.instr = {5'b00000, c_instr_i[5], c_instr_i[12:10], c_instr_i[6], 2'b00,
                          rs1_p, 3'b010, rd_rs2_p, OPCODE_LOAD};
      end

      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        // offset[6] and offset[5:2] split around the register fields
        result_o.instr = {5'b00000, c_instr_i[5], c_instr_i[12], rd_rs2_p, rs1_p, 3'b010,
                          c_instr_i[11:10], c_instr_i[6], 2'b00, OPCODE_STORE};
      end

      default: begin
        // 001 c.fld, 011 c.flw, 101 c.fsd, 111 c.fsw
        // 100 reserved
        // no fpu here, word stays zero
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== design/cdec_quad1.sv ====
// quadrant C1 expander
// immediates, jumps, lui, shifts, register alu ops and branches

module cdec_quad1
  import cdec_pkg::*;
(
  input  logic [CINSTR_W-1:0] c_instr_i,
  output exp_result_t         result_o
);

  // rd'/rs1' and rs2' in the x8..x15 window
  logic [4:0] rd_p;
  logic [4:0] rs2_p;
  // link target, x1 for c.jal and x0 for c.j
  logic [4:0] jal_rd;
  // funct fields of the register-register group
  logic [6:0] alu_funct7;
  logic [2:0] alu_funct3;

  assign rd_p   = {RVC_PRIME_PREFIX, c_instr_i[9:7]};
  assign rs2_p  = {RVC_PRIME_PREFIX, c_instr_i[4:2]};
  assign jal_rd = c_instr_i[15] ? 5'd0 : REG_RA;

  // 00 sub, 01 xor, 10 or, 11 and
  always_comb begin
    case (c_instr_i[6:5])
      2'b00:   alu_funct3 = 3'b000;
      2'b01:   alu_funct3 = 3'b100;
      2'b10:   alu_funct3 = 3'b110;
      default: alu_funct3 = 3'b111;
    endcase
  end
  // only sub sets bit 30
  assign alu_funct7 = (c_instr_i[6:5] == 2'b00) ? 7'b0100000 : 7'b0000000;

  always_comb begin
    result_o = '0;

    case (c_instr_i[15:13])
      3'b000: begin
        // c.addi / c.nop, hints with rd=0 or imm=0 expand the same way
        result_o.instr = {{6{c_instr_i[12]}}, c_instr_i[12], c_instr_i[6:2], c_instr_i[11:7],
                          3'b000, c_instr_i[11:7], OPCODE_OPIMM};
      end

      3'b001, 3'b101: begin
        // c.jal -> jal x1, off   c.j -> jal x0, off
        result_o.instr = {c_instr_i[12], c_instr_i[8], c_instr_i[10:9], c_instr_i[6],
                          c_instr_i[7], c_instr_i[2], c_instr_i[11], c_instr_i[5:3],
                          {9{c_instr_i[12]}}, jal_rd, OPCODE_JAL};
      end

      3'b010: begin
        // c.li -> addi rd, x0, imm (rd=0 is a hint)
        result_o.instr = {{6{c_instr_i[12]}}, c_instr_i[12], c_instr_i[6:2], 5'd0, 3'b000,
                          c_instr_i[11:7], OPCODE_OPIMM};
      end

      3'b011: begin
        if ({c_instr_i[12], c_instr_i[6:2]} == 6'd0) begin
          // zero immediate reserved for both addi16sp and lui
          result_o.illegal = 1'b1;
        end else if (c_instr_i[11:7] == REG_SP) begin
          // c.addi16sp -> addi x2, x2, nzimm*16
          result_o.instr = {{3{c_instr_i[12]}}, c_instr_i[4:3], c_instr_i[5], c_instr_i[2],
                            c_instr_i[6], 4'b0000, REG_SP, 3'b000, REG_SP, OPCODE_OPIMM};
        end else begin
          // c.lui -> lui rd, nzimm (rd=0 hint)
          result_o.instr = {{15{c_instr_i[12]}}, c_instr_i[6:2], c_instr_i[11:7], OPCODE_LUI};
        end
      end

      3'b100: begin
        case (c_instr_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 10 picks arithmetic
            result_o.instr = {1'b0, c_instr_i[10], 5'd0, c_instr_i[6:2], rd_p, 3'b101, rd_p,
                              OPCODE_OPIMM};
            // shamt[5] has no meaning on rv32
            result_o.illegal = c_instr_i[12];
          end
          2'b10: begin
            // c.andi -> andi rd', rd', imm
            result_o.instr = {{6{c_instr_i[12]}}, c_instr_i[12], c_instr_i[6:2], rd_p, 3'b111,
                              rd_p, OPCODE_OPIMM};
          end
          default: begin
            if (c_instr_i[12]) begin
              // c.subw, c.addw and the two reserved slots, rv64 only
              result_o.illegal = 1'b1;
            end else begin
              result_o.instr = {alu_funct7, rs2_p, rd_p, alu_funct3, rd_p, OPCODE_OP};
            end
          end
        endcase
      end

      default: begin
        // c.beqz / c.bnez, bit 13 becomes funct3[0]
        result_o.instr = {{4{c_instr_i[12]}}, c_instr_i[6:5], c_instr_i[2], 5'd0, rd_p, 2'b00,
                          c_instr_i[13], c_instr_i[11:10], c_instr_i[4:3], c_instr_i[12],
                          OPCODE_BRANCH};
      end
    endcase
  end

endmodule

// ==== design/cdec_quad2.sv ====
// quadrant C2 expander
// slli, sp-relative load/store, jr/jalr, mv/add and ebreak

module cdec_quad2
  import cdec_pkg::*;
(
  input  logic [CINSTR_W-1:0] c_instr_i,
  output exp_result_t         result_o
);

  // full 5-bit register fields of the C2 formats
  logic [4:0] rd;
  logic [4:0] rs2;

  assign rd  = c_instr_i[11:7];
  assign rs2 = c_instr_i[6:2];

  always_comb begin
    result_o = '0;

    case (c_instr_i[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt (rd=0 or shamt=0 hints)
        result_o.instr   = {7'd0, rs2, rd, 3'b001, rd, OPCODE_OPIMM};
        // shamt[5] set is reserved on rv32
        result_o.illegal = c_instr_i[12];
      end

      3'b010: begin
        // c.lwsp -> lw rd, uimm(x2)
        result_o.instr = {4'd0, c_instr_i[3:2], c_instr_i[12], c_instr_i[6:4], 2'b00, REG_SP,
                          3'b010, rd, OPCODE_LOAD};
        result_o.illegal = (rd == 5'd0);
      end

      3'b100: begin
        if (!c_instr_i[12]) begin
          if (rs2 == 5'd0) begin
            // c.jr -> jalr x0, 0(rs1)
            result_o.instr   = {12'd0, rd, 3'b000, 5'd0, OPCODE_JALR};
            // jr x0 is reserved
            result_o.illegal = (rd == 5'd0);
          end else begin
            // c.mv -> add rd, x0, rs2
            result_o.instr = {7'd0, rs2, 5'd0, 3'b000, rd, OPCODE_OP};
          end
        end else begin
          if (rs2 == 5'd0) begin
            if (rd == 5'd0) begin
              result_o.instr = EBREAK_INSTR;
            end else begin
              // c.jalr -> jalr x1, 0(rs1)
              result_o.instr = {12'd0, rd, 3'b000, REG_RA, OPCODE_JALR};
            end
          end else begin
            // c.add -> add rd, rd, rs2
            result_o.instr = {7'd0, rs2, rd, 3'b000, rd, OPCODE_OP};
          end
        end
      end

      3'b110: begin
        // c.swsp -> sw rs2, uimm(x2)
        result_o.instr = {4'd0, c_instr_i[8:7], c_instr_i[12], rs2, REG_SP, 3'b010,
                          c_instr_i[11:9], 2'b00, OPCODE_STORE};
      end

      default: begin
        // 001 c.fldsp, 011 c.flwsp, 101 c.fsdsp, 111 c.fswsp
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== design/cdec_credit_cnt.sv ====
// downstream credit counter
// starts full, spends one per accept, gains one per returned credit

module cdec_credit_cnt #(
  parameter int unsigned CREDITS_MAX = 4
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic take_i,
  input  logic return_i,
  output logic credits_avail_o
);

  // wide enough to hold CREDITS_MAX itself
  localparam int unsigned CNT_W = $clog2(CREDITS_MAX + 1);

  logic [CNT_W-1:0] count_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_q <= CNT_W'(CREDITS_MAX);
    end else begin
      // take and return together cancel out
      if (take_i && !return_i) begin
        count_q <= count_q - 1'b1;
      end else if (return_i && !take_i) begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // the consumer never returns more than it took
  // so the count stays within 0..CREDITS_MAX

  assign credits_avail_o = (count_q != '0);

endmodule

// ==== design/cdec_stage.sv ====
// decode stage
// picks quadrant or pass-through result and registers it one cycle after accept

module cdec_stage
  import cdec_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        in_valid_i,
  input  instr_t      in_instr_i,
  input  logic        credits_avail_i,
  input  exp_result_t quad0_i,
  input  exp_result_t quad1_i,
  input  exp_result_t quad2_i,
  output logic        take_o,
  output logic        out_valid_o,
  output dec_result_t out_result_o
);

  dec_result_t dec_d;
  dec_result_t result_q;
  logic        valid_q;

  // accept needs a free slot downstream
  assign take_o = in_valid_i && credits_avail_i;

  ////////////////////////////////////////////////////////////////////////////
  // result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_d.compressed = (in_instr_i[1:0] != QUAD_FULL);
    case (in_instr_i[1:0])
      QUAD_C0: {dec_d.instr, dec_d.illegal} = quad0_i;
      QUAD_C1: {dec_d.instr, dec_d.illegal} = quad1_i;
      QUAD_C2: {dec_d.instr, dec_d.illegal} = quad2_i;
      // full word, untouched and never flagged
      default: {dec_d.instr, dec_d.illegal} = {in_instr_i, 1'b0};
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  // valid lasts exactly one cycle per accept
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= take_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_o) begin
      result_q <= dec_d;
    end
  end

  assign out_valid_o  = valid_q;
  assign out_result_o = result_q;

endmodule

// ==== design/cdec_top.sv ====
// rv32c expansion stage, top level
// expanders, result register and credit counter

module cdec_top
  import cdec_pkg::*;
#(
  parameter int unsigned CREDITS_MAX = 4
) (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        in_valid_i,
  input  instr_t      in_instr_i,
  output logic        in_ready_o,
  output logic        out_valid_o,
  output dec_result_t out_result_o,
  input  logic        credit_return_i
);

  exp_result_t quad0_res;
  exp_result_t quad1_res;
  exp_result_t quad2_res;
  logic        take;
  logic        credits_avail;

  // all three expanders see the low parcel, the stage picks one
  cdec_quad0 cdec_quad0_i (
    .c_instr_i (in_instr_i[CINSTR_W-1:0]),
    .result_o  (quad0_res)
  );

  cdec_quad1 cdec_quad1_i (
    .c_instr_i (in_instr_i[CINSTR_W-1:0]),
    .result_o  (quad1_res)
  );

  cdec_quad2 cdec_quad2_i (
    .c_instr_i (in_instr_i[CINSTR_W-1:0]),
    .result_o  (quad2_res)
  );

  cdec_stage cdec_stage_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_valid_i      (in_valid_i),
    .in_instr_i      (in_instr_i),
    .credits_avail_i (credits_avail),
    .quad0_i         (quad0_res),
    .quad1_i         (quad1_res),
    .quad2_i         (quad2_res),
    .take_o          (take),
    .out_valid_o     (out_valid_o),
    .out_result_o    (out_result_o)
  );

  cdec_credit_cnt #(
    .CREDITS_MAX (CREDITS_MAX)
  ) cdec_credit_cnt_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .take_i          (take),
    .return_i        (credit_return_i),
    .credits_avail_o (credits_avail)
  );

  // ready as long as one credit is left
  assign in_ready_o = credits_avail;

endmodule

// ==== tb/cdec_tb.sv ====
// cdec testbench
// file-driven fetch words, credit back-pressure and in-order result checks

module cdec_tb
  import cdec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic        clk;
  logic        rst_n;
  logic        in_valid;
  instr_t      in_instr;
  logic        in_ready;
  logic        out_valid;
  dec_result_t out_result;
  logic        credit_return;

  // vectors from the data file
  instr_t      stim_q[$];
  dec_result_t want_q[$];
  // expected results of accepted words, oldest first
  dec_result_t exp_q[$];
  instr_t      src_q[$];
  // cycles at which one credit goes back
  int          return_due[$];

  int          seed;
  int          num_tests;
  int          credits_max;
  int          cycle;
  int          cycle_limit;
  // delivered results whose credit is still held downstream
  int          outstanding;

  cdec_top cdec_top_i (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .in_valid_i      (in_valid),
    .in_instr_i      (in_instr),
    .in_ready_o      (in_ready),
    .out_valid_o     (out_valid),
    .out_result_o    (out_result),
    .credit_return_i (credit_return)
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  // limit is set once the test count is known
  initial begin : watchdog
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle++;
      if (cycle_limit > 0 && cycle > cycle_limit) begin
        abort_run($sformatf("timeout: run not finished within %0d cycles", cycle_limit));
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string msg);
    $display("sim failed");
    $display("%s", msg);
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got %0h expected %0h", name, got, exp));
    end
  endtask

  // credits in use never exceed the buffer depth
  task automatic check_count(input int got);
    if (got < 0 || got > credits_max) begin
      abort_run($sformatf("Mismatch outstanding results: got %0h limit %0h",
                          got, credits_max));
    end
  endtask

  task automatic check_result(input dec_result_t got);
    dec_result_t exp;
    instr_t      src;
    if (exp_q.size() == 0) begin
      abort_run($sformatf("unexpected output %09h with no word accepted", got));
    end else begin
      exp = exp_q.pop_front();
      src = src_q.pop_front();
      if (got.compressed !== exp.compressed) begin
        abort_run($sformatf("Mismatch out_result_o.compressed for %08h: got %0h expected %0h",
                            src, got.compressed, exp.compressed));
      end
      if (got.illegal !== exp.illegal) begin
        abort_run($sformatf("Mismatch out_result_o.illegal for %08h: got %0h expected %0h",
                            src, got.illegal, exp.illegal));
      end
      // an illegal word has no defined expansion
      if (!exp.illegal && got.instr !== exp.instr) begin
        abort_run($sformatf("Mismatch out_result_o.instr for %08h: got %08h expected %08h",
                            src, got.instr, exp.instr));
      end
    end
  endtask

  // one test per line, lines starting with # are skipped
  task automatic load_tests();
    int          fd;
    int          fields;
    string       line;
    instr_t      word;
    instr_t      instr;
    logic        cflag;
    logic        iflag;
    dec_result_t want;
    fd = $fopen("tb/cdec_tests.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the test file tb/cdec_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%h %h %h %h", word, instr, cflag, iflag);
          if (fields == 4) begin
            want.instr      = instr;
            want.compressed = cflag;
            want.illegal    = iflag;
            stim_q.push_back(word);
            want_q.push_back(want);
          end
        end
      end
      $fclose(fd);
      num_tests = stim_q.size();
      if (num_tests == 0) begin
        abort_run("the test file holds no tests");
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus and checks, all on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    logic accepted;
    logic ready_seen;
    logic hold_credits;
    logic saw_full;
    int   full_cycles;
    int   idle_left;
    int   next_in;
    int   next_out;

    seed          = 32'hd9ba;
    rst_n         = 1'b0;
    in_valid      = 1'b0;
    in_instr      = '0;
    credit_return = 1'b0;
    outstanding   = 0;
    hold_credits  = 1'b1;
    saw_full      = 1'b0;
    full_cycles   = 0;
    idle_left     = 0;
    next_in       = 0;
    next_out      = 0;

    load_tests();
    credits_max = cdec_top_i.CREDITS_MAX;
    cycle_limit = 20 * num_tests + 100;

    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    // state left by reset
    compare_flag("in_ready_o", in_ready, 1'b1);
    compare_flag("out_valid_o", out_valid, 1'b0);
    ready_seen = in_ready;

    while (next_out < num_tests) begin
      @(negedge clk);
      // accept and credit return of the rising edge just passed
      accepted = in_valid && ready_seen;
      if (accepted) begin
        exp_q.push_back(want_q[next_in]);
        src_q.push_back(stim_q[next_in]);
        next_in++;
      end

      // a delivered result holds its credit until the buffer returns it
      if (out_valid) begin
        outstanding++;
      end
      if (credit_return) begin
        outstanding--;
      end
      check_count(outstanding);

      // result is due in the cycle right after its accept
      if (out_valid) begin
        check_result(out_result);
        next_out++;
        return_due.push_back(cycle + int'($unsigned($random(seed)) % 6));
      end
      compare_flag("out_valid_o", out_valid, accepted);
      compare_flag("in_ready_o", in_ready, outstanding < credits_max);
      ready_seen = in_ready;

      // credits held back at first until the buffer sits full
      if (!in_ready) begin
        saw_full = 1'b1;
        full_cycles++;
      end
      if (hold_credits && full_cycles >= 3) begin
        hold_credits = 1'b0;
      end
      credit_return = 1'b0;
      if (!hold_credits && return_due.size() > 0) begin
        if (return_due[0] <= cycle) begin
          void'(return_due.pop_front());
          credit_return = 1'b1;
        end
      end

      // a stalled word stays on the bus until taken
      if (!in_valid || accepted) begin
        in_valid = 1'b0;
        in_instr = instr_t'($random(seed));
        if (next_in < num_tests) begin
          if (idle_left > 0) begin
            idle_left--;
          end else begin
            in_valid  = 1'b1;
            in_instr  = stim_q[next_in];
            idle_left = int'($unsigned($random(seed)) % 3);
          end
        end
      end
    end

    // nothing more may come out
    repeat (3) begin
      @(negedge clk);
      // last credit pulse ends after one edge
      credit_return = 1'b0;
      compare_flag("out_valid_o", out_valid, 1'b0);
    end

    if (saw_full) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("in_ready_o never dropped while credits were withheld");
    end
  end

endmodule

// ==== cdec.f ====
design/cdec_pkg.sv
design/cdec_quad0.sv
design/cdec_quad1.sv
design/cdec_quad2.sv
design/cdec_credit_cnt.sv
design/cdec_stage.sv
design/cdec_top.sv
tb/cdec_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cdec testbench with verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f cdec.f --top-module cdec_tb -o cdec_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/cdec_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulator exited with status $status"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "no pass line found in $LOG"
  exit 1
fi
exit 0

// ==== tb/cdec_tests.txt ====
# columns: input word, expected instruction, compressed flag, illegal flag (all hex)
# illegal rows carry a zero instruction, only the flags are compared there
00001FE4 3FC10493 1 0
000041C8 0045A503 1 0
0000C504 00952423 1 0
00000000 00000000 1 1
00002000 00000000 1 1
00008000 00000000 1 1
DEAD0001 00000013 1 0
0000157D FFF50513 1 0
00000281 00028293 1 0
00002009 002000EF 1 0
00003001 801FF0EF 1 0
0000BFFD FFFFF06F 1 0
0000467D 01F00613 1 0
00005001 FE000013 1 0
00007101 E0010113 1 0
00006785 000017B7 1 0
00006101 00000000 1 1
000084FD 41F4D493 1 0
0000900D 00000000 1 1
00009941 FF057513 1 0
00008C05 40940433 1 0
00008E55 00D66633 1 0
00009C05 00000000 1 1
0000FCFD FE049FE3 1 0
00000292 00429293 1 0
000053FE 0FC12383 1 0
00004002 00000000 1 1
DEAD8082 00008067 1 0
00008002 00000000 1 1
0000852E 00B00533 1 0
00008016 00500033 1 0
00009002 00100073 1 0
00009282 000280E7 1 0
00009426 00940433 1 0
0000C62A 00A12623 1 0
0000E002 00000000 1 1
00B50533 00B50533 0 0
FFFFFFFF FFFFFFFF 0 0
12345677 12345677 0 0
